/* hw/mgt_pkg.sv */
// Shared constants, register map and state types for the transceiver channel block
// Referenced by scoped name from every RTL module
`default_nettype none

package mgt_pkg;

  // Bus geometry
  localparam int NUM_LANES       = 2;
  localparam int REG_AWIDTH      = 16;
  localparam int REG_DWIDTH      = 32;
  localparam int LANE_BLOCK_SIZE = 32'h1000;
  localparam int LANE_OFFS_W     = $clog2(LANE_BLOCK_SIZE);
  localparam int PORTNUM_BASE    = 4;

  // Register offsets within a lane block
  localparam logic [LANE_OFFS_W-1:0] REG_PORT_INFO  = 12'h000;
  localparam logic [LANE_OFFS_W-1:0] REG_CONTROL    = 12'h004;
  localparam logic [LANE_OFFS_W-1:0] REG_STATUS     = 12'h008;
  localparam logic [LANE_OFFS_W-1:0] REG_WORD_COUNT = 12'h00C;
  localparam logic [LANE_OFFS_W-1:0] REG_SCRATCH    = 12'h010;

  // Timing
  localparam int READ_TIMEOUT      = 16;
  localparam logic [REG_DWIDTH-1:0] TIMEOUT_DATA = 32'hDEADBEEF;
  localparam int LINK_TRAIN_CYCLES = 32;
  localparam int ACTIVITY_HOLD     = 8;

  // Counter widths and their load or end values
  localparam int TMO_CNT_W   = $clog2(READ_TIMEOUT + 1);
  localparam int TRAIN_CNT_W = $clog2(LINK_TRAIN_CYCLES + 1);
  localparam int ACT_CNT_W   = $clog2(ACTIVITY_HOLD + 1);
  localparam logic [TMO_CNT_W-1:0]   TMO_LOAD   = TMO_CNT_W'(READ_TIMEOUT - 1);
  localparam logic [TRAIN_CNT_W-1:0] TRAIN_LAST = TRAIN_CNT_W'(LINK_TRAIN_CYCLES - 1);
  localparam logic [ACT_CNT_W-1:0]   ACT_LOAD   = ACT_CNT_W'(ACTIVITY_HOLD);

  typedef enum logic [1:0] {LINK_DOWN, LINK_TRAIN, LINK_UP} link_state_e;

  typedef enum logic [2:0] {
    BR_IDLE, BR_WRITE, BR_READ_WAIT, BR_ACK, BR_RELEASE
  } bridge_state_e;

  typedef enum logic {OP_READ, OP_WRITE} reg_op_e;

endpackage

`default_nettype wire

/* hw/regport_if.sv */
// Register port between the host bridge, the response mux and the lanes
// Requests are single-cycle pulses, reads answer with one rd_resp pulse
`default_nettype none

interface regport_if;

  // Write channel
  logic                            wr_req;
  logic [mgt_pkg::REG_AWIDTH-1:0] wr_addr;
  logic [mgt_pkg::REG_DWIDTH-1:0] wr_data;

  // Read channel
  logic                            rd_req;
  logic [mgt_pkg::REG_AWIDTH-1:0] rd_addr;
  logic                            rd_resp;
  logic [mgt_pkg::REG_DWIDTH-1:0] rd_data;

  modport master (
    output wr_req, wr_addr, wr_data,
    output rd_req, rd_addr,
    input  rd_resp, rd_data
  );

  modport slave (
    input  wr_req, wr_addr, wr_data,
    input  rd_req, rd_addr,
    output rd_resp, rd_data
  );

endinterface

`default_nettype wire

/* hw/regport_host_bridge.sv */
// Four-phase req/ack host port to register-port master
// Reads give up after READ_TIMEOUT cycles and report an error with filler data
`default_nettype none

module regport_host_bridge (
  input  wire                             bus_clk_i,
  input  wire                             rst_i,
  input  wire                             host_req_i,
  input  mgt_pkg::reg_op_e                host_op_i,
  input  wire [mgt_pkg::REG_AWIDTH-1:0]  host_addr_i,
  input  wire [mgt_pkg::REG_DWIDTH-1:0]  host_wdata_i,
  output logic                            host_ack_o,
  output logic                            host_err_o,
  output logic [mgt_pkg::REG_DWIDTH-1:0] host_rdata_o,
  regport_if.master                       regp
);

  mgt_pkg::bridge_state_e state;

  logic                             wr_req_q;
  logic                             rd_req_q;
  logic [mgt_pkg::REG_AWIDTH-1:0]  addr_q;
  logic [mgt_pkg::REG_DWIDTH-1:0]  wdata_q;
  logic [mgt_pkg::TMO_CNT_W-1:0]   tmo_cnt;

  // --------------------------------------------------
  // Register-port drive
  // --------------------------------------------------
  assign regp.wr_req  = wr_req_q;
  assign regp.wr_addr = addr_q;
  assign regp.wr_data = wdata_q;
  assign regp.rd_req  = rd_req_q;
  assign regp.rd_addr = addr_q;

  // Host address and write data, captured once per transaction
  always_ff @(posedge bus_clk_i) begin
    if (state == mgt_pkg::BR_IDLE && host_req_i) begin
      addr_q  <= host_addr_i;
      wdata_q <= host_wdata_i;
    end
  end

  // --------------------------------------------------
  // Handshake FSM
  // --------------------------------------------------
  always_ff @(posedge bus_clk_i) begin
    if (rst_i) begin
      state      <= mgt_pkg::BR_IDLE;
      wr_req_q   <= 1'b0;
      rd_req_q   <= 1'b0;
      tmo_cnt    <= '0;
      host_ack_o <= 1'b0;
      host_err_o <= 1'b0;
    end else begin
      // Request pulses last exactly one cycle
      wr_req_q <= 1'b0;
      rd_req_q <= 1'b0;
      case (state)
        mgt_pkg::BR_IDLE: begin
          if (host_req_i) begin
            if (host_op_i == mgt_pkg::OP_WRITE) begin
              wr_req_q <= 1'b1;
              state    <= mgt_pkg::BR_WRITE;
            end else begin
              rd_req_q <= 1'b1;
              tmo_cnt  <= mgt_pkg::TMO_LOAD;
              state    <= mgt_pkg::BR_READ_WAIT;
            end
          end
        end
        mgt_pkg::BR_WRITE: begin
          host_ack_o <= 1'b1;
          host_err_o <= 1'b0;
          state      <= mgt_pkg::BR_ACK;
        end
        mgt_pkg::BR_READ_WAIT: begin
          if (regp.rd_resp) begin
            host_rdata_o <= regp.rd_data;
            host_err_o   <= 1'b0;
            host_ack_o   <= 1'b1;
            state        <= mgt_pkg::BR_ACK;
          end else if (tmo_cnt == '0) begin
            // Nobody decoded the address
            host_rdata_o <= mgt_pkg::TIMEOUT_DATA;
            host_err_o   <= 1'b1;
            host_ack_o   <= 1'b1;
            state        <= mgt_pkg::BR_ACK;
          end else begin
            tmo_cnt <= tmo_cnt - 1'b1;
          end
        end
        mgt_pkg::BR_ACK: begin
          if (!host_req_i) begin
            host_ack_o <= 1'b0;
            state      <= mgt_pkg::BR_RELEASE;
          end
        end
        default: begin
          // Ack is low here, host may start again
          state <= mgt_pkg::BR_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/regport_resp_mux.sv */
// Broadcasts register-port requests to every lane and merges read responses
`default_nettype none

module regport_resp_mux (
  input  wire        bus_clk_i,
  input  wire        rst_i,
  regport_if.slave   host,
  regport_if.master  lanes [mgt_pkg::NUM_LANES]
);

  logic [mgt_pkg::NUM_LANES-1:0]   resp_vec;
  logic [mgt_pkg::REG_DWIDTH-1:0]  data_vec [mgt_pkg::NUM_LANES];
  logic [mgt_pkg::REG_DWIDTH-1:0]  data_or;
  logic                             resp_q;
  logic [mgt_pkg::REG_DWIDTH-1:0]  data_q;

  // Requests go straight through to all lanes
  for (genvar i = 0; i < mgt_pkg::NUM_LANES; i++) begin : g_lane
    assign lanes[i].wr_req  = host.wr_req;
    assign lanes[i].wr_addr = host.wr_addr;
    assign lanes[i].wr_data = host.wr_data;
    assign lanes[i].rd_req  = host.rd_req;
    assign lanes[i].rd_addr = host.rd_addr;
    assign resp_vec[i]      = lanes[i].rd_resp;
    assign data_vec[i]      = lanes[i].rd_data;
  end

  // Idle lanes drive zero data, so OR picks the responder
  always_comb begin
    data_or = '0;
    for (int k = 0; k < mgt_pkg::NUM_LANES; k++) begin
      data_or = data_or | data_vec[k];
    end
  end

  always_ff @(posedge bus_clk_i) begin
    if (rst_i) begin
      resp_q <= 1'b0;
    end else begin
      resp_q <= |resp_vec;
    end
    data_q <= data_or;
  end

  assign host.rd_resp = resp_q;
  assign host.rd_data = data_q;

endmodule

`default_nettype wire

/* hw/mgt_lane.sv */
// One transceiver lane: register block, link-state FSM, rx word counter
// and activity stretcher. LANE_IDX selects the address window and port number
`default_nettype none

module mgt_lane #(
  parameter int LANE_IDX = 0
) (
  input  wire                             bus_clk_i,
  input  wire                             rst_i,
  regport_if.slave                        regp,
  input  wire                             mod_present_n_i,
  input  wire                             mod_tx_fault_i,
  input  wire                             rx_sigdet_i,
  input  wire                             rx_valid_i,
  output logic                            tx_disable_o,
  output logic                            link_up_o,
  output logic                            activity_o,
  output logic [mgt_pkg::REG_DWIDTH-1:0] port_info_o
);

  mgt_pkg::link_state_e link_state;

  logic [mgt_pkg::REG_AWIDTH-mgt_pkg::LANE_OFFS_W-1:0] lane_sel;
  logic [mgt_pkg::LANE_OFFS_W-1:0]   wr_offs;
  logic [mgt_pkg::LANE_OFFS_W-1:0]   rd_offs;
  logic                               wr_hit;
  logic                               rd_hit;
  logic                               cnt_clear;
  logic                               mod_present;
  logic                               link_ok;
  logic                               rx_word;
  logic [mgt_pkg::REG_DWIDTH-1:0]    scratch_q;
  logic [mgt_pkg::REG_DWIDTH-1:0]    word_cnt;
  logic [mgt_pkg::REG_DWIDTH-1:0]    status;
  logic [mgt_pkg::REG_DWIDTH-1:0]    rd_mux;
  logic [mgt_pkg::TRAIN_CNT_W-1:0]   train_cnt;
  logic [mgt_pkg::ACT_CNT_W-1:0]     act_cnt;

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------
  assign lane_sel = ($bits(lane_sel))'(LANE_IDX);
  assign wr_offs  = regp.wr_addr[mgt_pkg::LANE_OFFS_W-1:0];
  assign rd_offs  = regp.rd_addr[mgt_pkg::LANE_OFFS_W-1:0];
  assign wr_hit   = regp.wr_req &&
                    (regp.wr_addr[mgt_pkg::REG_AWIDTH-1:mgt_pkg::LANE_OFFS_W] == lane_sel);
  assign rd_hit   = regp.rd_req &&
                    (regp.rd_addr[mgt_pkg::REG_AWIDTH-1:mgt_pkg::LANE_OFFS_W] == lane_sel);

  // Bit 1 of control is a strobe, never stored
  assign cnt_clear = wr_hit && (wr_offs == mgt_pkg::REG_CONTROL) && regp.wr_data[1];

  assign port_info_o = {16'h0000, 8'(mgt_pkg::PORTNUM_BASE + LANE_IDX),
                        8'(mgt_pkg::NUM_LANES)};
  assign mod_present = ~mod_present_n_i;
  assign status      = {29'd0, mod_tx_fault_i, mod_present, link_up_o};

  always_ff @(posedge bus_clk_i) begin
    if (rst_i) begin
      tx_disable_o <= 1'b0;
      scratch_q    <= '0;
    end else if (wr_hit) begin
      if (wr_offs == mgt_pkg::REG_CONTROL) begin
        tx_disable_o <= regp.wr_data[0];
      end
      if (wr_offs == mgt_pkg::REG_SCRATCH) begin
        scratch_q <= regp.wr_data;
      end
    end
  end

  always_comb begin
    case (rd_offs)
      mgt_pkg::REG_PORT_INFO:  rd_mux = port_info_o;
      mgt_pkg::REG_CONTROL:    rd_mux = {31'd0, tx_disable_o};
      mgt_pkg::REG_STATUS:     rd_mux = status;
      mgt_pkg::REG_WORD_COUNT: rd_mux = word_cnt;
      mgt_pkg::REG_SCRATCH:    rd_mux = scratch_q;
      default:                 rd_mux = '0;
    endcase
  end

  // Data stays zero unless this lane answers, the mux ORs all lanes
  always_ff @(posedge bus_clk_i) begin
    if (rst_i) begin
      regp.rd_resp <= 1'b0;
      regp.rd_data <= '0;
    end else begin
      regp.rd_resp <= rd_hit;
      regp.rd_data <= rd_hit ? rd_mux : '0;
    end
  end

  // --------------------------------------------------
  // Link state
  // --------------------------------------------------
  assign link_ok   = rx_sigdet_i && mod_present && !tx_disable_o;
  assign link_up_o = (link_state == mgt_pkg::LINK_UP);

  always_ff @(posedge bus_clk_i) begin
    if (rst_i) begin
      link_state <= mgt_pkg::LINK_DOWN;
      train_cnt  <= '0;
    end else if (!link_ok) begin
      link_state <= mgt_pkg::LINK_DOWN;
    end else begin
      case (link_state)
        mgt_pkg::LINK_DOWN: begin
          train_cnt  <= '0;
          link_state <= mgt_pkg::LINK_TRAIN;
        end
        mgt_pkg::LINK_TRAIN: begin
          if (train_cnt == mgt_pkg::TRAIN_LAST) begin
            link_state <= mgt_pkg::LINK_UP;
          end else begin
            train_cnt <= train_cnt + 1'b1;
          end
        end
        default: link_state <= mgt_pkg::LINK_UP;
      endcase
    end
  end

  // --------------------------------------------------
  // Rx word counter and activity
  // --------------------------------------------------
  assign rx_word    = rx_valid_i && link_up_o;
  assign activity_o = (act_cnt != '0);

  always_ff @(posedge bus_clk_i) begin
    if (rst_i) begin
      word_cnt <= '0;
      act_cnt  <= '0;
    end else begin
      if (cnt_clear) begin
        word_cnt <= '0;
      end else if (rx_word && word_cnt != '1) begin
        word_cnt <= word_cnt + 1'b1;
      end
      // Retrigger on every word
      if (rx_word) begin
        act_cnt <= mgt_pkg::ACT_LOAD;
      end else if (act_cnt != '0) begin
        act_cnt <= act_cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/mgt_channel_top.sv */
// Transceiver channel top: host bridge, response mux and one mgt_lane per lane
// Host side is a four-phase req/ack register port
`default_nettype none

module mgt_channel_top (
  input  wire                                              bus_clk_i,
  input  wire                                              rst_i,
  // Host port
  input  wire                                              host_req_i,
  input  mgt_pkg::reg_op_e                                 host_op_i,
  input  wire [mgt_pkg::REG_AWIDTH-1:0]                   host_addr_i,
  input  wire [mgt_pkg::REG_DWIDTH-1:0]                   host_wdata_i,
  output logic                                             host_ack_o,
  output logic                                             host_err_o,
  output logic [mgt_pkg::REG_DWIDTH-1:0]                  host_rdata_o,
  // Module sideband, shared by all lanes
  input  wire                                              mod_present_n_i,
  input  wire                                              mod_tx_fault_i,
  output logic                                             mod_tx_disable_o,
  // Per-lane signals
  input  wire  [mgt_pkg::NUM_LANES-1:0]                   rx_sigdet_i,
  input  wire  [mgt_pkg::NUM_LANES-1:0]                   rx_valid_i,
  output logic [mgt_pkg::NUM_LANES-1:0]                   link_up_o,
  output logic [mgt_pkg::NUM_LANES-1:0]                   activity_o,
  output logic [mgt_pkg::NUM_LANES*mgt_pkg::REG_DWIDTH-1:0] port_info_o
);

  logic [mgt_pkg::NUM_LANES-1:0] tx_disable;

  regport_if host_bus ();
  regport_if lane_bus [mgt_pkg::NUM_LANES] ();

  // One module cage, any lane may hold the laser off
  assign mod_tx_disable_o = |tx_disable;

  regport_host_bridge u_bridge (
    .bus_clk_i    (bus_clk_i),
    .rst_i        (rst_i),
    .host_req_i   (host_req_i),
    .host_op_i    (host_op_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_ack_o   (host_ack_o),
    .host_err_o   (host_err_o),
    .host_rdata_o (host_rdata_o),
    .regp         (host_bus)
  );

  regport_resp_mux u_resp_mux (
    .bus_clk_i (bus_clk_i),
    .rst_i     (rst_i),
    .host      (host_bus),
    .lanes     (lane_bus)
  );

  for (genvar l = 0; l < mgt_pkg::NUM_LANES; l++) begin : g_lanes
    mgt_lane #(
      .LANE_IDX (l)
    ) u_lane (
      .bus_clk_i       (bus_clk_i),
      .rst_i           (rst_i),
      .regp            (lane_bus[l]),
      .mod_present_n_i (mod_present_n_i),
      .mod_tx_fault_i  (mod_tx_fault_i),
      .rx_sigdet_i     (rx_sigdet_i[l]),
      .rx_valid_i      (rx_valid_i[l]),
      .tx_disable_o    (tx_disable[l]),
      .link_up_o       (link_up_o[l]),
      .activity_o      (activity_o[l]),
      .port_info_o     (port_info_o[l*mgt_pkg::REG_DWIDTH +: mgt_pkg::REG_DWIDTH])
    );
  end

endmodule

`default_nettype wire

/* sim/tb_mgt_channel.sv */
// Self-checking testbench for the transceiver channel top
// Drives the four-phase host port and lane inputs, checks reads against a shadow model
`default_nettype none

module tb_mgt_channel;
  timeunit 1ns;
  timeprecision 1ps;

  logic                                              clk;
  logic                                              rst;
  logic                                              host_req;
  mgt_pkg::reg_op_e                                  host_op;
  logic [mgt_pkg::REG_AWIDTH-1:0]                   host_addr;
  logic [mgt_pkg::REG_DWIDTH-1:0]                   host_wdata;
  logic                                              host_ack;
  logic                                              host_err;
  logic [mgt_pkg::REG_DWIDTH-1:0]                   host_rdata;
  logic                                              mod_present_n;
  logic                                              mod_tx_fault;
  logic                                              mod_tx_disable;
  logic [mgt_pkg::NUM_LANES-1:0]                    rx_sigdet;
  logic [mgt_pkg::NUM_LANES-1:0]                    rx_valid;
  logic [mgt_pkg::NUM_LANES-1:0]                    link_up;
  logic [mgt_pkg::NUM_LANES-1:0]                    activity;
  logic [mgt_pkg::NUM_LANES*mgt_pkg::REG_DWIDTH-1:0] port_info;

  // Shadow state for the expected values
  logic [31:0] scratch_sh [mgt_pkg::NUM_LANES];
  logic [31:0] count_sh   [mgt_pkg::NUM_LANES];
  logic        txdis_sh   [mgt_pkg::NUM_LANES];
  logic        link_sh    [mgt_pkg::NUM_LANES];
  logic [mgt_pkg::NUM_LANES-1:0] act_seen;

  integer seed = 19879;
  int     cycle_cnt = 0;

  mgt_channel_top u_dut (
    .bus_clk_i        (clk),
    .rst_i            (rst),
    .host_req_i       (host_req),
    .host_op_i        (host_op),
    .host_addr_i      (host_addr),
    .host_wdata_i     (host_wdata),
    .host_ack_o       (host_ack),
    .host_err_o       (host_err),
    .host_rdata_o     (host_rdata),
    .mod_present_n_i  (mod_present_n),
    .mod_tx_fault_i   (mod_tx_fault),
    .mod_tx_disable_o (mod_tx_disable),
    .rx_sigdet_i      (rx_sigdet),
    .rx_valid_i       (rx_valid),
    .link_up_o        (link_up),
    .activity_o       (activity),
    .port_info_o      (port_info)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  // About 300 host cycles of 25 clocks each, plus link training and traffic
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= 20000) begin
      fail_run("Timeout: the run did not complete within 20000 cycles");
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      fail_run($sformatf("Mismatch %s: expected %08h, actual %08h", name, exp, act));
    end
  endtask

  function automatic logic [15:0] lane_addr(input int lane, input logic [11:0] offs);
    return 16'(lane * mgt_pkg::LANE_BLOCK_SIZE) | {4'd0, offs};
  endfunction

  // Expected {err, data} from the address map and the shadow registers
  function automatic logic [32:0] model_read(input logic [15:0] addr);
    int          lane;
    logic [11:0] offs;
    logic [31:0] d;
    lane = int'(addr) / mgt_pkg::LANE_BLOCK_SIZE;
    offs = addr[11:0];
    if (lane >= mgt_pkg::NUM_LANES) begin
      return {1'b1, mgt_pkg::TIMEOUT_DATA};
    end
    case (offs)
      mgt_pkg::REG_PORT_INFO:
        d = {16'd0, 8'(mgt_pkg::PORTNUM_BASE + lane), 8'(mgt_pkg::NUM_LANES)};
      mgt_pkg::REG_CONTROL:    d = {31'd0, txdis_sh[lane]};
      mgt_pkg::REG_STATUS:     d = {29'd0, mod_tx_fault, ~mod_present_n, link_sh[lane]};
      mgt_pkg::REG_WORD_COUNT: d = count_sh[lane];
      mgt_pkg::REG_SCRATCH:    d = scratch_sh[lane];
      default:                 d = 32'd0;
    endcase
    return {1'b0, d};
  endfunction

  // --------------------------------------------------
  // Four-phase host transfers
  // --------------------------------------------------
  task automatic host_xfer(input mgt_pkg::reg_op_e op, input logic [15:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic err);
    @(negedge clk);
    host_op    = op;
    host_addr  = addr;
    host_wdata = wdata;
    host_req   = 1'b1;
    while (!host_ack) @(negedge clk);
    rdata    = host_rdata;
    err      = host_err;
    host_req = 1'b0;
    while (host_ack) @(negedge clk);
  endtask

  task automatic host_write(input logic [15:0] addr, input logic [31:0] wdata);
    logic [31:0] unused_data;
    logic        unused_err;
    host_xfer(mgt_pkg::OP_WRITE, addr, wdata, unused_data, unused_err);
  endtask

  task automatic check_read(input string name, input logic [15:0] addr);
    logic [31:0] data;
    logic        err;
    logic [32:0] exp;
    host_xfer(mgt_pkg::OP_READ, addr, 32'd0, data, err);
    exp = model_read(addr);
    check_value({name, " data"}, exp[31:0], data);
    check_value({name, " err"}, 32'(exp[32]), 32'(err));
  endtask

  // Bounded wait for one lane's link to reach a level
  task automatic wait_link(input int lane, input logic want);
    int n;
    n = 0;
    while (link_up[lane] !== want && n < mgt_pkg::LINK_TRAIN_CYCLES + 4) begin
      @(negedge clk);
      n++;
    end
    if (link_up[lane] !== want) begin
      fail_run($sformatf("Link of lane %0d did not reach %0b in time", lane, want));
    end
    link_sh[lane] = want;
  endtask

  initial begin
    int          lane;
    int          kind;
    logic [11:0] offs;
    logic [31:0] data;
    logic [32:0] model_val;

    rst           = 1'b1;
    host_req      = 1'b0;
    host_op       = mgt_pkg::OP_READ;
    host_addr     = '0;
    host_wdata    = '0;
    mod_present_n = 1'b1;
    mod_tx_fault  = 1'b0;
    rx_sigdet     = '0;
    rx_valid      = '0;
    act_seen      = '0;
    for (int l = 0; l < mgt_pkg::NUM_LANES; l++) begin
      scratch_sh[l] = '0;
      count_sh[l]   = '0;
      txdis_sh[l]   = 1'b0;
      link_sh[l]    = 1'b0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Reset values and port info
    check_value("link_up after reset", 32'(link_up), 32'd0);
    check_value("activity after reset", 32'(activity), 32'd0);
    check_value("tx_disable after reset", 32'(mod_tx_disable), 32'd0);
    check_value("ack after reset", 32'(host_ack), 32'd0);
    for (int l = 0; l < mgt_pkg::NUM_LANES; l++) begin
      check_read("port info", lane_addr(l, mgt_pkg::REG_PORT_INFO));
      model_val = model_read(lane_addr(l, mgt_pkg::REG_PORT_INFO));
      check_value("port_info_o", model_val[31:0], port_info[l*32 +: 32]);
    end

    // --------------------------------------------------
    // Random scratch and unmapped traffic
    // --------------------------------------------------
    for (int i = 0; i < 200; i++) begin
      lane = int'({$random(seed)} % mgt_pkg::NUM_LANES);
      kind = int'({$random(seed)} % 4);
      offs = 12'h014 + 12'(4 * ({$random(seed)} % 1000));
      data = $random(seed);
      case (kind)
        0: begin
          host_write(lane_addr(lane, mgt_pkg::REG_SCRATCH), data);
          scratch_sh[lane] = data;
        end
        1: check_read("scratch", lane_addr(lane, mgt_pkg::REG_SCRATCH));
        2: host_write(lane_addr(lane, offs), data);
        default: check_read("unmapped", lane_addr(lane, offs));
      endcase
    end
    for (int l = 0; l < mgt_pkg::NUM_LANES; l++) begin
      check_read("scratch final", lane_addr(l, mgt_pkg::REG_SCRATCH));
    end

    // Nobody decodes beyond the last lane
    check_read("out of range", lane_addr(mgt_pkg::NUM_LANES, mgt_pkg::REG_SCRATCH));
    check_read("after timeout", lane_addr(0, mgt_pkg::REG_SCRATCH));

    // --------------------------------------------------
    // Link training and status
    // --------------------------------------------------
    @(negedge clk);
    mod_present_n = 1'b0;
    mod_tx_fault  = 1'b1;
    rx_sigdet     = '1;
    for (int l = 0; l < mgt_pkg::NUM_LANES; l++) begin
      wait_link(l, 1'b1);
      check_read("status up", lane_addr(l, mgt_pkg::REG_STATUS));
    end
    rx_sigdet[1] = 1'b0;
    @(negedge clk);
    wait_link(1, 1'b0);
    check_read("status down", lane_addr(1, mgt_pkg::REG_STATUS));
    rx_sigdet[1]  = 1'b1;
    mod_tx_fault  = 1'b0;
    wait_link(1, 1'b1);
    check_read("status retrain", lane_addr(1, mgt_pkg::REG_STATUS));

    // Received words, first cycle busy on every lane
    for (int c = 0; c < 60; c++) begin
      @(negedge clk);
      act_seen = act_seen | activity;
      rx_valid = (c == 0) ? '1 : mgt_pkg::NUM_LANES'($random(seed));
      for (int l = 0; l < mgt_pkg::NUM_LANES; l++) begin
        if (rx_valid[l]) begin
          count_sh[l] = count_sh[l] + 1;
        end
      end
    end
    @(negedge clk);
    act_seen = act_seen | activity;
    rx_valid = '0;
    check_value("activity seen", 32'(act_seen), 32'((1 << mgt_pkg::NUM_LANES) - 1));
    for (int l = 0; l < mgt_pkg::NUM_LANES; l++) begin
      check_read("word count", lane_addr(l, mgt_pkg::REG_WORD_COUNT));
      host_write(lane_addr(l, mgt_pkg::REG_CONTROL), 32'h2);
      count_sh[l] = '0;
      check_read("word count cleared", lane_addr(l, mgt_pkg::REG_WORD_COUNT));
      check_read("control after clear", lane_addr(l, mgt_pkg::REG_CONTROL));
    end

    // --------------------------------------------------
    // Tx disable on lane 0
    // --------------------------------------------------
    host_write(lane_addr(0, mgt_pkg::REG_CONTROL), 32'h1);
    txdis_sh[0] = 1'b1;
    check_value("tx_disable set", 32'(mod_tx_disable), 32'd1);
    wait_link(0, 1'b0);
    check_value("lane 1 stays up", 32'(link_up[1]), 32'd1);
    check_read("control disabled", lane_addr(0, mgt_pkg::REG_CONTROL));
    check_read("status disabled", lane_addr(0, mgt_pkg::REG_STATUS));
    host_write(lane_addr(0, mgt_pkg::REG_CONTROL), 32'h0);
    txdis_sh[0] = 1'b0;
    check_value("tx_disable clear", 32'(mod_tx_disable), 32'd0);
    wait_link(0, 1'b1);
    check_read("status enabled", lane_addr(0, mgt_pkg::REG_STATUS));

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
hw/mgt_pkg.sv
hw/regport_if.sv
hw/regport_host_bridge.sv
hw/regport_resp_mux.sv
hw/mgt_lane.sv
hw/mgt_channel_top.sv
sim/tb_mgt_channel.sv

/* Makefile */
TOP = tb_mgt_channel

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f build.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only --timing -f build.f --top-module mgt_channel_top

clean:
	rm -rf obj_dir
